// File: hw/cache_cfg_pkg.sv
// ####################
// cache geometry and the basic vector types
// imported by every cache module and by the bus package
// ####################
`default_nettype none

package cache_cfg_pkg;

    // address and data widths
    localparam int addr_width = 32;
    localparam int word_width = 32;

    // byte lanes in a word and bits to select one
    localparam int byte_lanes = word_width / 8;
    localparam int byte_offset_bits = $clog2(byte_lanes);

    // fixed block of 8 words
    localparam int block_words = 8;
    localparam int offset_bits = $clog2(block_words);

    // first address bit above the block offset
    localparam int block_lsb = offset_bits + byte_offset_bits;

    // tag is the whole block number, index bits included
    localparam int tag_width = addr_width - block_lsb;

    typedef logic [addr_width-1:0] addr_t;
    typedef logic [word_width-1:0] word_t;
    typedef logic [offset_bits-1:0] offset_t;
    typedef logic [tag_width-1:0] tag_t;
    typedef logic [byte_lanes-1:0] byte_mask_t;

    // word 0 sits in the low bits
    typedef word_t [block_words-1:0] block_t;

endpackage

`default_nettype wire

// File: hw/cache_bus_pkg.sv
// ####################
// request and response structs of the cpu and memory ports
// plus the controller state encoding
// ####################
`default_nettype none

package cache_bus_pkg;

    import cache_cfg_pkg::*;

    // cpu side, one word per request
    typedef struct packed {
        logic write;
        addr_t addr;
        word_t data;
        byte_mask_t byte_mask;
    } cpu_req_t;

    typedef struct packed {
        word_t data;
        logic hit;
    } cpu_resp_t;

    // next level side, whole blocks
    // addr is always block aligned
    typedef struct packed {
        logic write;
        addr_t addr;
        block_t data;
    } mem_req_t;

    // for a write this only acknowledges
    typedef struct packed {
        block_t data;
    } mem_resp_t;

    // controller fsm
    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_write_back,
        st_fill,
        st_respond
    } ctrl_state_t;

endpackage

`default_nettype wire

// File: hw/cache_lru.sv
// ####################
// true lru by per-way age counters
// one counter set per cache set, victim is the oldest way
// ####################
`timescale 1ns/1ns
`default_nettype none

module cache_lru #(
    parameter int sets = 8,
    parameter int ways = 4,
    localparam int index_bits = $clog2(sets),
    localparam int way_bits = $clog2(ways)
) (
    input  logic clock,
    input  logic reset,
    input  logic [index_bits-1:0] index,
    input  logic touch,
    input  logic [way_bits-1:0] touch_way,
    output logic [way_bits-1:0] victim_way
);

    // ages run 0 (newest) to ways-1 (oldest)
    typedef logic [way_bits-1:0] age_t;

    age_t ages [sets][ways];
    age_t touched_age;
    age_t oldest_age;

    // age of the touched way before the update
    assign touched_age = ages[index][touch_way];

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            // way order, highest way is oldest
            for (int s = 0; s < sets; s++) begin
                for (int w = 0; w < ways; w++) begin
                    ages[s][w] <= age_t'(w);
                end
            end
        end else if (touch) begin
            for (int w = 0; w < ways; w++) begin
                if (way_bits'(w) == touch_way) begin
                    ages[index][w] <= '0;
                end else if (ages[index][w] < touched_age) begin
                    // only ways younger than the touched one move up
                    ages[index][w] <= ages[index][w] + 1'b1;
                end
            end
        end
    end

    // max search, ages in a set stay a permutation
    always_comb begin
        victim_way = '0;
        oldest_age = ages[index][0];
        for (int w = 1; w < ways; w++) begin
            if (ages[index][w] > oldest_age) begin
                oldest_age = ages[index][w];
                victim_way = way_bits'(w);
            end
        end
    end

endmodule

`default_nettype wire

// File: hw/cache_tag_store.sv
// ####################
// tag, valid and dirty bits per set and way
// parallel hit compare and victim status for the lru way
// ####################
`timescale 1ns/1ns
`default_nettype none

module cache_tag_store
    import cache_cfg_pkg::*;
#(
    parameter int sets = 8,
    parameter int ways = 4,
    localparam int index_bits = $clog2(sets),
    localparam int way_bits = $clog2(ways)
) (
    input  logic clock,
    input  logic reset,
    input  logic [index_bits-1:0] index,
    input  tag_t tag,
    input  logic [way_bits-1:0] victim_way,
    input  logic tag_write,
    input  logic [way_bits-1:0] write_way,
    input  logic set_dirty,
    output logic hit,
    output logic [way_bits-1:0] hit_way,
    output logic victim_valid,
    output logic victim_dirty,
    output tag_t victim_tag
);

    tag_t tags [sets][ways];
    logic [ways-1:0] valid_bits [sets];
    logic [ways-1:0] dirty_bits [sets];

    // valid and dirty bits of every line
    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int s = 0; s < sets; s++) begin
                valid_bits[s] <= '0;
                dirty_bits[s] <= '0;
            end
        end else if (tag_write) begin
            // install or write hit
            valid_bits[index][write_way] <= 1'b1;
            dirty_bits[index][write_way] <= set_dirty;
        end
    end

    // tag written on install and on a write hit
    always_ff @(posedge clock) begin
        if (tag_write) begin
            tags[index][write_way] <= tag;
        end
    end

    // compare against every way of the set
    always_comb begin
        hit = 1'b0;
        hit_way = '0;
        for (int w = 0; w < ways; w++) begin
            if (valid_bits[index][w] && tags[index][w] == tag) begin
                hit = 1'b1;
                hit_way = way_bits'(w);
            end
        end
    end

    // status of the line the lru wants to evict
    assign victim_valid = valid_bits[index][victim_way];
    assign victim_dirty = dirty_bits[index][victim_way];
    assign victim_tag = tags[index][victim_way];

endmodule

`default_nettype wire

// File: hw/cache_data_store.sv
// ####################
// block storage of the cache
// masked word writes, whole block fill, combinational read
// ####################
`timescale 1ns/1ns
`default_nettype none

module cache_data_store
    import cache_cfg_pkg::*;
#(
    parameter int sets = 8,
    parameter int ways = 4,
    localparam int index_bits = $clog2(sets),
    localparam int way_bits = $clog2(ways)
) (
    input  logic clock,
    input  logic reset,
    input  logic [index_bits-1:0] index,
    input  logic [way_bits-1:0] read_way,
    input  offset_t offset,
    input  logic word_write,
    input  byte_mask_t byte_mask,
    input  word_t write_word,
    input  logic fill,
    input  block_t fill_block,
    output word_t read_word,
    output block_t read_block
);

    block_t blocks [sets][ways];
    block_t merged_block;

    // new block content for the addressed way
    always_comb begin
        if (fill) begin
            merged_block = fill_block;
        end else begin
            merged_block = blocks[index][read_way];
        end
        // on write allocate the cpu bytes win over the fetched word
        if (word_write) begin
            for (int b = 0; b < byte_lanes; b++) begin
                if (byte_mask[b]) begin
                    merged_block[offset][8*b +: 8] = write_word[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            for (int s = 0; s < sets; s++) begin
                for (int w = 0; w < ways; w++) begin
                    blocks[s][w] <= '0;
                end
            end
        end else if (fill || word_write) begin
            blocks[index][read_way] <= merged_block;
        end
    end

    // victim block for write-back, word for the cpu
    assign read_block = blocks[index][read_way];
    assign read_word = read_block[offset];

endmodule

`default_nettype wire

// File: hw/cache_controller.sv
// ####################
// blocking cache fsm through lookup, write-back, fill and respond
// drives the stores and the lru, owns both external ports
// ####################
`timescale 1ns/1ns
`default_nettype none

module cache_controller
    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;
#(
    parameter int sets = 8,
    parameter int ways = 4,
    localparam int index_bits = $clog2(sets),
    localparam int way_bits = $clog2(ways)
) (
    input  logic clock,
    input  logic reset,
    // cpu port
    input  logic cpu_req_valid,
    input  cpu_req_t cpu_req,
    output logic cpu_resp_valid,
    output cpu_resp_t cpu_resp,
    // next level port
    output logic mem_req_valid,
    output mem_req_t mem_req,
    input  logic mem_resp_valid,
    input  mem_resp_t mem_resp,
    // address of the held request
    output logic [index_bits-1:0] index,
    output tag_t tag,
    output offset_t offset,
    // tag store
    input  logic hit,
    input  logic [way_bits-1:0] hit_way,
    input  logic victim_valid,
    input  logic victim_dirty,
    input  tag_t victim_tag,
    output logic tag_write,
    output logic [way_bits-1:0] write_way,
    output logic set_dirty,
    // data store
    output logic [way_bits-1:0] data_way,
    output logic data_word_write,
    output byte_mask_t byte_mask,
    output word_t write_word,
    output logic data_fill,
    output block_t fill_block,
    input  word_t read_word,
    input  block_t read_block,
    // lru
    input  logic [way_bits-1:0] victim_way,
    output logic lru_touch,
    output logic [way_bits-1:0] touch_way
);

    ctrl_state_t state;
    cpu_req_t req_q;
    logic hit_q;
    logic install_q;
    logic [way_bits-1:0] access_way_q;
    block_t fill_block_q;
    mem_req_t fill_req;
    logic victim_writeback;
    logic lookup_hit;
    logic installing;

    // tag is the block number, index its low bits
    assign tag = req_q.addr[addr_width-1:block_lsb];
    assign index = tag[index_bits-1:0];
    assign offset = req_q.addr[block_lsb-1:byte_offset_bits];

    assign victim_writeback = victim_valid && victim_dirty;
    assign lookup_hit = (state == st_lookup) && hit;
    // second fill cycle with the block already registered
    assign installing = (state == st_fill) && install_q;

    // block read for the held address
    always_comb begin
        fill_req.write = 1'b0;
        fill_req.addr = {tag, {block_lsb{1'b0}}};
        fill_req.data = '0;
    end

    always_ff @(posedge clock or negedge reset) begin
        if (!reset) begin
            state <= st_idle;
            hit_q <= 1'b0;
            install_q <= 1'b0;
            access_way_q <= '0;
            mem_req_valid <= 1'b0;
        end else begin
            // single cycle strobe
            mem_req_valid <= 1'b0;
            case (state)
                st_idle: begin
                    if (cpu_req_valid) begin
                        state <= st_lookup;
                    end
                end
                st_lookup: begin
                    hit_q <= hit;
                    if (hit) begin
                        access_way_q <= hit_way;
                        state <= st_respond;
                    end else begin
                        // victim way held until the response
                        access_way_q <= victim_way;
                        mem_req_valid <= 1'b1;
                        state <= victim_writeback ? st_write_back : st_fill;
                    end
                end
                st_write_back: begin
                    // ack in, read out next cycle
                    if (mem_resp_valid) begin
                        mem_req_valid <= 1'b1;
                        state <= st_fill;
                    end
                end
                st_fill: begin
                    if (install_q) begin
                        install_q <= 1'b0;
                        state <= st_respond;
                    end else if (mem_resp_valid) begin
                        install_q <= 1'b1;
                    end
                end
                st_respond: begin
                    state <= st_idle;
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        // requests outside idle are dropped
        if (state == st_idle && cpu_req_valid) begin
            req_q <= cpu_req;
        end
        if (state == st_fill && mem_resp_valid) begin
            fill_block_q <= mem_resp.data;
        end
        if (state == st_lookup && !hit) begin
            if (victim_writeback) begin
                // evicted block goes back under its own block number
                mem_req.write <= 1'b1;
                mem_req.addr <= {victim_tag, {block_lsb{1'b0}}};
                mem_req.data <= read_block;
            end else begin
                mem_req <= fill_req;
            end
        end
        if (state == st_write_back && mem_resp_valid) begin
            mem_req <= fill_req;
        end
    end

    // lookup uses the live hit or victim way, later states the held one
    always_comb begin
        if (state == st_lookup) begin
            data_way = hit ? hit_way : victim_way;
        end else begin
            data_way = access_way_q;
        end
    end

    // write hit marks dirty, install sets dirty for a write miss
    assign tag_write = (lookup_hit && req_q.write) || installing;
    assign write_way = (state == st_lookup) ? hit_way : access_way_q;
    assign set_dirty = req_q.write;

    // merge with the fill on a write miss
    assign data_word_write = req_q.write && (lookup_hit || installing);
    assign byte_mask = req_q.byte_mask;
    assign write_word = req_q.data;
    assign data_fill = installing;
    assign fill_block = fill_block_q;

    // accessed way becomes newest when the access completes
    assign lru_touch = (state == st_respond);
    assign touch_way = access_way_q;

    assign cpu_resp_valid = (state == st_respond);
    always_comb begin
        cpu_resp.data = read_word;
        cpu_resp.hit = hit_q;
    end

endmodule

`default_nettype wire

// File: hw/cache_top.sv
// ####################
// data cache top, cpu port in, block memory port out
// sets and ways are chosen here
// ####################
`timescale 1ns/1ns
`default_nettype none

module cache_top
    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;
#(
    parameter int sets = 8,
    parameter int ways = 4
) (
    input  logic clock,
    input  logic reset,
    input  logic cpu_req_valid,
    input  cpu_req_t cpu_req,
    output logic cpu_resp_valid,
    output cpu_resp_t cpu_resp,
    output logic mem_req_valid,
    output mem_req_t mem_req,
    input  logic mem_resp_valid,
    input  mem_resp_t mem_resp
);

    localparam int index_bits = $clog2(sets);
    localparam int way_bits = $clog2(ways);

    // address of the request in service
    logic [index_bits-1:0] index;
    tag_t tag;
    offset_t offset;

    // tag store
    logic hit;
    logic [way_bits-1:0] hit_way;
    logic victim_valid;
    logic victim_dirty;
    tag_t victim_tag;
    logic tag_write;
    logic [way_bits-1:0] write_way;
    logic set_dirty;

    // data store
    logic [way_bits-1:0] data_way;
    logic data_word_write;
    byte_mask_t byte_mask;
    word_t write_word;
    logic data_fill;
    block_t fill_block;
    word_t read_word;
    block_t read_block;

    // lru
    logic [way_bits-1:0] victim_way;
    logic lru_touch;
    logic [way_bits-1:0] touch_way;

    cache_controller #(
        .sets(sets),
        .ways(ways)
    ) controller_i (
        .clock(clock),
        .reset(reset),
        .cpu_req_valid(cpu_req_valid),
        .cpu_req(cpu_req),
        .cpu_resp_valid(cpu_resp_valid),
        .cpu_resp(cpu_resp),
        .mem_req_valid(mem_req_valid),
        .mem_req(mem_req),
        .mem_resp_valid(mem_resp_valid),
        .mem_resp(mem_resp),
        .index(index),
        .tag(tag),
        .offset(offset),
        .hit(hit),
        .hit_way(hit_way),
        .victim_valid(victim_valid),
        .victim_dirty(victim_dirty),
        .victim_tag(victim_tag),
        .tag_write(tag_write),
        .write_way(write_way),
        .set_dirty(set_dirty),
        .data_way(data_way),
        .data_word_write(data_word_write),
        .byte_mask(byte_mask),
        .write_word(write_word),
        .data_fill(data_fill),
        .fill_block(fill_block),
        .read_word(read_word),
        .read_block(read_block),
        .victim_way(victim_way),
        .lru_touch(lru_touch),
        .touch_way(touch_way)
    );

    cache_tag_store #(
        .sets(sets),
        .ways(ways)
    ) tag_store_i (
        .clock(clock),
        .reset(reset),
        .index(index),
        .tag(tag),
        .victim_way(victim_way),
        .tag_write(tag_write),
        .write_way(write_way),
        .set_dirty(set_dirty),
        .hit(hit),
        .hit_way(hit_way),
        .victim_valid(victim_valid),
        .victim_dirty(victim_dirty),
        .victim_tag(victim_tag)
    );

    cache_data_store #(
        .sets(sets),
        .ways(ways)
    ) data_store_i (
        .clock(clock),
        .reset(reset),
        .index(index),
        .read_way(data_way),
        .offset(offset),
        .word_write(data_word_write),
        .byte_mask(byte_mask),
        .write_word(write_word),
        .fill(data_fill),
        .fill_block(fill_block),
        .read_word(read_word),
        .read_block(read_block)
    );

    cache_lru #(
        .sets(sets),
        .ways(ways)
    ) lru_i (
        .clock(clock),
        .reset(reset),
        .index(index),
        .touch(lru_touch),
        .touch_way(touch_way),
        .victim_way(victim_way)
    );

endmodule

`default_nettype wire

// File: tb/tb_clock_gen.sv
// ####################
// testbench clock and reset
// reset is low for the first cycles, then released
// ####################
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int period = 100,
    parameter int reset_cycles = 4
) (
    output logic clock,
    output logic reset
);

    // free running, starts low
    initial begin
        clock = 1'b0;
        forever #(period / 2) clock = ~clock;
    end

    // released just after an edge, away from the sampling point
    initial begin
        reset = 1'b0;
        repeat (reset_cycles) @(posedge clock);
        #1;
        reset = 1'b1;
    end

endmodule

`default_nettype wire

// File: tb/cache_checker.sv
// ####################
// reference model of the cache contents and lru order
// watches the dut ports and compares every answer and memory request
// ####################
`timescale 1ns/1ns
`default_nettype none

module cache_checker
    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;
#(
    parameter int sets = 8,
    parameter int ways = 4
) (
    input  logic clock,
    input  logic reset,
    input  logic cpu_req_valid,
    input  cpu_req_t cpu_req,
    input  logic cpu_resp_valid,
    input  cpu_resp_t cpu_resp,
    input  logic mem_req_valid,
    input  mem_req_t mem_req,
    output int tests_done,
    output int error_count
);

    localparam int index_bits = $clog2(sets);

    // words the cpu wrote, the rest still hold the start pattern
    word_t ref_words [addr_t];
    // resident blocks of each set, slot 0 is the newest
    tag_t res_block [sets][ways];
    logic res_dirty [sets][ways];
    int res_count [sets];
    logic set_seen [sets];

    // access in service and what it has to do
    logic pending;
    cpu_req_t pend_req;
    int pend_set;
    int pend_cycle;
    int pend_errors;
    logic first_access;
    logic exp_hit;
    logic exp_wb;
    addr_t wb_addr;
    block_t wb_block;
    addr_t fill_addr;
    word_t exp_data;
    int mem_seen;
    int cycle = 0;
    int tests = 0;
    int errors = 0;

    assign tests_done = tests;
    assign error_count = errors;

    // every word address gives its own value
    function automatic word_t initial_word(input addr_t word_addr);
        return (word_addr * 32'h9e37_79b1) ^ {word_addr[15:0], word_addr[31:16]};
    endfunction

    function automatic word_t ref_word(input addr_t word_addr);
        if (ref_words.exists(word_addr)) begin
            return ref_words[word_addr];
        end
        return initial_word(word_addr);
    endfunction

    task automatic flag_error(input string text);
        $display("%s", text);
        errors++;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            flag_error($sformatf("Error: %s expected %h got %h", name, expected, actual));
        end
    endtask

    task automatic clear_model();
        ref_words.delete();
        for (int s = 0; s < sets; s++) begin
            res_count[s] = 0;
            set_seen[s] = 1'b0;
        end
        pending = 1'b0;
    endtask

    // hit, victim and data under true lru, model updated at once
    task automatic predict_access(input cpu_req_t req);
        tag_t block;
        logic [index_bits-1:0] set_index;
        addr_t word_addr;
        word_t merged;
        int pos;
        logic was_dirty;
        block = req.addr[addr_width-1:block_lsb];
        set_index = block[index_bits-1:0];
        pend_set = int'(set_index);
        word_addr = {req.addr[addr_width-1:2], 2'b00};
        first_access = !set_seen[set_index];
        set_seen[set_index] = 1'b1;
        pos = -1;
        for (int i = 0; i < res_count[set_index]; i++) begin
            if (res_block[set_index][i] == block) begin
                pos = i;
            end
        end
        exp_hit = (pos >= 0);
        exp_wb = 1'b0;
        was_dirty = 1'b0;
        fill_addr = {block, {block_lsb{1'b0}}};
        if (exp_hit) begin
            was_dirty = res_dirty[set_index][pos];
        end else if (res_count[set_index] == ways) begin
            // full set, the oldest block leaves
            pos = ways - 1;
            exp_wb = res_dirty[set_index][pos];
            wb_addr = {res_block[set_index][pos], {block_lsb{1'b0}}};
            for (int w = 0; w < block_words; w++) begin
                wb_block[w] = ref_word(wb_addr + addr_t'(4 * w));
            end
        end else begin
            pos = res_count[set_index];
            res_count[set_index]++;
        end
        // accessed block moves to the front
        for (int i = pos; i > 0; i--) begin
            res_block[set_index][i] = res_block[set_index][i-1];
            res_dirty[set_index][i] = res_dirty[set_index][i-1];
        end
        res_block[set_index][0] = block;
        res_dirty[set_index][0] = was_dirty || req.write;
        if (req.write) begin
            merged = ref_word(word_addr);
            for (int b = 0; b < byte_lanes; b++) begin
                if (req.byte_mask[b]) begin
                    merged[8*b +: 8] = req.data[8*b +: 8];
                end
            end
            ref_words[word_addr] = merged;
        end
        exp_data = ref_word(word_addr);
    endtask

    // write-back first when the victim is dirty, then the block read
    task automatic check_mem_request();
        int wb_slots;
        wb_slots = exp_wb ? 1 : 0;
        if (!pending) begin
            flag_error("memory request with no cpu request in service");
        end else if (exp_hit) begin
            flag_error($sformatf("memory request to %h during a hit", mem_req.addr));
        end else if (mem_seen < wb_slots) begin
            check_value("mem_req.write", 1, mem_req.write);
            check_value("mem_req.addr", wb_addr, mem_req.addr);
            for (int w = 0; w < block_words; w++) begin
                check_value($sformatf("mem_req.data[%0d]", w), wb_block[w], mem_req.data[w]);
            end
        end else if (mem_seen == wb_slots) begin
            check_value("mem_req.write", 0, mem_req.write);
            check_value("mem_req.addr", fill_addr, mem_req.addr);
        end else begin
            flag_error("more memory requests than the miss needs");
        end
        mem_seen++;
    endtask

    task automatic finish_access();
        int expected_mem;
        string kind;
        string verdict;
        if (!pending) begin
            flag_error("cpu response with no request in service");
        end else begin
            check_value("cpu_resp.hit", exp_hit, cpu_resp.hit);
            if (first_access && cpu_resp.hit) begin
                flag_error($sformatf("first access to set %0d reported a hit", pend_set));
            end
            if (exp_hit && cycle - pend_cycle != 2) begin
                flag_error($sformatf("hit answered %0d cycles after the request, not 2",
                                     cycle - pend_cycle));
            end
            expected_mem = exp_hit ? 0 : (exp_wb ? 2 : 1);
            if (mem_seen != expected_mem) begin
                flag_error($sformatf("access ended after %0d memory requests, %0d expected",
                                     mem_seen, expected_mem));
            end
            // write answers carry no checked data
            if (!pend_req.write) begin
                check_value("cpu_resp.data", exp_data, cpu_resp.data);
            end
            if (exp_hit) begin
                kind = "hit";
            end else if (exp_wb) begin
                kind = "miss with write-back";
            end else begin
                kind = "miss";
            end
            if (errors == pend_errors) begin
                verdict = "ok";
            end else begin
                verdict = "mismatch";
            end
            tests++;
            $display("test %0d: %s %h %s, %s", tests, pend_req.write ? "write" : "read",
                     pend_req.addr, kind, verdict);
            pending = 1'b0;
        end
    endtask

    // all ports are stable half a cycle after the edge
    always @(negedge clock) begin
        cycle++;
        if (!reset) begin
            if (cpu_resp_valid) begin
                flag_error("cpu_resp_valid high during reset");
            end
            if (mem_req_valid) begin
                flag_error("mem_req_valid high during reset");
            end
            clear_model();
        end else begin
            if (cpu_resp_valid) begin
                finish_access();
            end
            if (mem_req_valid) begin
                check_mem_request();
            end
            if (cpu_req_valid) begin
                if (pending) begin
                    flag_error("cpu request while another one was in service");
                end else begin
                    pending = 1'b1;
                    pend_req = cpu_req;
                    pend_cycle = cycle;
                    pend_errors = errors;
                    mem_seen = 0;
                    predict_access(cpu_req);
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: tb/cache_tb.sv
// ####################
// testbench top with clock, dut, block memory model and random cpu requests
// the checker compares, this module ends the run and reports
// ####################
`timescale 1ns/1ns
`default_nettype none

module cache_tb
    import cache_cfg_pkg::*;
    import cache_bus_pkg::*;
#(
    parameter int sets = 8,
    parameter int ways = 4,
    parameter int num_requests = 500
) ();

    localparam int index_bits = $clog2(sets);
    localparam int max_mem_delay = 6;
    // dirty miss with two slow memory answers, plus install, respond and idle
    localparam int worst_access_cycles = 2 * (max_mem_delay + 2) + 4;
    localparam int timeout_cycles = num_requests * worst_access_cycles + 200;

    logic clock;
    logic reset;
    logic cpu_req_valid;
    cpu_req_t cpu_req;
    logic cpu_resp_valid;
    cpu_resp_t cpu_resp;
    logic mem_req_valid;
    mem_req_t mem_req;
    logic mem_resp_valid;
    mem_resp_t mem_resp;
    int tests_done;
    int error_count;
    int cycle_count;
    int seed;

    // next level memory holding the words written back so far
    word_t mem_words [addr_t];

    tb_clock_gen #(
        .period(100),
        .reset_cycles(4)
    ) clock_gen_i (
        .clock(clock),
        .reset(reset)
    );

    cache_top #(
        .sets(sets),
        .ways(ways)
    ) cache_top_i (
        .clock(clock),
        .reset(reset),
        .cpu_req_valid(cpu_req_valid),
        .cpu_req(cpu_req),
        .cpu_resp_valid(cpu_resp_valid),
        .cpu_resp(cpu_resp),
        .mem_req_valid(mem_req_valid),
        .mem_req(mem_req),
        .mem_resp_valid(mem_resp_valid),
        .mem_resp(mem_resp)
    );

    cache_checker #(
        .sets(sets),
        .ways(ways)
    ) checker_i (
        .clock(clock),
        .reset(reset),
        .cpu_req_valid(cpu_req_valid),
        .cpu_req(cpu_req),
        .cpu_resp_valid(cpu_resp_valid),
        .cpu_resp(cpu_resp),
        .mem_req_valid(mem_req_valid),
        .mem_req(mem_req),
        .tests_done(tests_done),
        .error_count(error_count)
    );

    // every word address gives its own value
    function automatic word_t initial_word(input addr_t word_addr);
        return (word_addr * 32'h9e37_79b1) ^ {word_addr[15:0], word_addr[31:16]};
    endfunction

    // mostly two hot sets with six blocks each, so lines get evicted
    task automatic random_request(output cpu_req_t req);
        int set_index;
        int k;
        int high;
        tag_t block;
        if ($unsigned($random(seed)) % 4 != 0) begin
            set_index = ($unsigned($random(seed)) % 2 == 0) ? 2 : 5;
        end else begin
            set_index = int'($unsigned($random(seed)) % sets);
        end
        k = int'($unsigned($random(seed)) % 6);
        high = 32'h0000_4a10 + k * 32'h0003_0101;
        block = tag_t'((high << index_bits) | set_index);
        req.write = 1'($random(seed));
        req.addr = {block, offset_t'($random(seed)), 2'($random(seed))};
        req.data = $random(seed);
        req.byte_mask = byte_mask_t'($random(seed));
    endtask

    // one cycle strobe, then wait for the answer
    task automatic issue_request(input cpu_req_t req);
        cpu_req = req;
        cpu_req_valid = 1'b1;
        @(posedge clock);
        #1;
        cpu_req_valid = 1'b0;
        do begin
            @(negedge clock);
        end while (!cpu_resp_valid);
    endtask

    initial begin : stimulus
        cpu_req_t req;
        seed = 32'hd632;
        cpu_req_valid = 1'b0;
        cpu_req = '0;
        @(posedge reset);
        for (int n = 0; n < num_requests; n++) begin
            @(posedge clock);
            #1;
            random_request(req);
            issue_request(req);
        end
        // checker finishes the last answer first
        repeat (2) @(posedge clock);
        $display("requests: %0d, checked: %0d, errors: %0d",
                 num_requests, tests_done, error_count);
        if (error_count == 0 && tests_done == num_requests) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // answers each request after 1 to 6 cycles
    initial begin : memory_model
        mem_req_t req;
        mem_resp_t resp;
        addr_t word_addr;
        int delay;
        mem_resp_valid = 1'b0;
        mem_resp = '0;
        forever begin
            @(negedge clock);
            if (mem_req_valid) begin
                req = mem_req;
                resp = '0;
                delay = 1 + int'($unsigned($random(seed)) % max_mem_delay);
                for (int w = 0; w < block_words; w++) begin
                    word_addr = req.addr + addr_t'(4 * w);
                    if (req.write) begin
                        mem_words[word_addr] = req.data[w];
                    end else if (mem_words.exists(word_addr)) begin
                        resp.data[w] = mem_words[word_addr];
                    end else begin
                        resp.data[w] = initial_word(word_addr);
                    end
                end
                repeat (delay) @(posedge clock);
                #1;
                mem_resp = resp;
                mem_resp_valid = 1'b1;
                @(posedge clock);
                #1;
                mem_resp_valid = 1'b0;
            end
        end
    end

    // stops a hung dut
    initial begin : timeout_watch
        cycle_count = 0;
        while (cycle_count < timeout_cycles) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout after %0d cycles, %0d of %0d requests answered",
                 cycle_count, tests_done, num_requests);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
hw/cache_cfg_pkg.sv
hw/cache_bus_pkg.sv
hw/cache_lru.sv
hw/cache_tag_store.sv
hw/cache_data_store.sv
hw/cache_controller.sv
hw/cache_top.sv
tb/tb_clock_gen.sv
tb/cache_checker.sv
tb/cache_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the cache testbench with verilator, run it, check the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal -j 0 --top-module cache_tb -f all.f -o cache_sim

./obj_dir/cache_sim | tee sim.log

if grep -q "Simulation FAILED" sim.log; then
    echo "run failed, see sim.log"
    exit 1
fi
if ! grep -q "Simulation PASSED" sim.log; then
    echo "run ended without a result, see sim.log"
    exit 1
fi
echo "run passed"
